// ==== tb.f ====
cplx_bus_pkg.sv
cplx_map_pkg.sv
obi_spill_cut.sv
region_decoder.sv
obi_target_demux.sv
core_complex_top.sv
core_complex_assertions.sv
tb_core_complex.sv

// ==== Makefile ====
# Verilator flow for the core complex testbench

TOP := tb_core_complex

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only cplx_bus_pkg.sv cplx_map_pkg.sv obi_spill_cut.sv \
		region_decoder.sv obi_target_demux.sv core_complex_top.sv \
		--top-module core_complex_top
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

# The log decides the result, since the simulator output goes through tee
sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_core_complex.sv ====
/*
  Testbench for core_complex_top with the default 1 KiB window at 0x0010_0000.
  Plays the core and models external data memory, instruction memory and
  the accelerator configuration port. Core accesses are issued one at a
  time. The run stops at the first mismatch or timeout.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_core_complex
  import cplx_bus_pkg::*;
  import cplx_map_pkg::*;
();

  localparam int unsigned N_CORES     = 8;
  localparam logic [31:0] RegionStart = DefaultRegionStart;
  localparam logic [31:0] RegionSize  = DefaultRegionSize;
  localparam int          Timeout     = 100;
  localparam logic [31:0] Seed        = 32'd28223;
  localparam logic [31:0] PeriphXor   = 32'hA5A5_0000;
  localparam logic [31:0] InstXor     = 32'h1357_9BDF;
  localparam int          NumAccesses = 20;
  localparam int          NumFetches  = 6;
  localparam int          NumEvtRuns  = 24;

  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    target_e     tgt;
    logic [31:0] rdata;
  } access_t;

  // Each row holds we, addr, wdata, be, expected target and expected read data
  localparam access_t Accesses [NumAccesses] = '{
    '{1'b1, 32'h0010_0000, 32'hCAFE_0001, 4'hF, AccelTgt,    32'h0000_0000},
    '{1'b0, 32'h0010_0000, 32'h0000_0000, 4'hF, AccelTgt,    32'hA5B5_0000},
    '{1'b1, 32'h0010_03FC, 32'h1234_5678, 4'h3, AccelTgt,    32'h0000_0000},
    '{1'b0, 32'h0010_03FC, 32'h0000_0000, 4'hF, AccelTgt,    32'hA5B5_03FC},
    '{1'b1, 32'h0010_0200, 32'h0BAD_F00D, 4'hC, AccelTgt,    32'h0000_0000},
    '{1'b0, 32'h0010_0204, 32'h0000_0000, 4'hF, AccelTgt,    32'hA5B5_0204},
    '{1'b1, 32'h0000_0000, 32'h1122_3344, 4'hF, ExternalTgt, 32'h0000_0000},
    '{1'b1, 32'h0000_0000, 32'hAABB_CCDD, 4'h5, ExternalTgt, 32'h0000_0000},
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 4'hF, ExternalTgt, 32'h11BB_33DD},
    '{1'b1, 32'h000F_FFFC, 32'h0F0F_0F0F, 4'hF, ExternalTgt, 32'h0000_0000},
    '{1'b0, 32'h000F_FFFC, 32'h0000_0000, 4'hF, ExternalTgt, 32'h0F0F_0F0F},
    '{1'b1, 32'h0010_0400, 32'h5566_7788, 4'hF, ExternalTgt, 32'h0000_0000},
    '{1'b1, 32'h0010_0400, 32'h0000_99AA, 4'h2, ExternalTgt, 32'h0000_0000},
    '{1'b0, 32'h0010_0400, 32'h0000_0000, 4'hF, ExternalTgt, 32'h5566_9988},
    '{1'b1, 32'h8000_0000, 32'hDEAD_BEEF, 4'hF, ExternalTgt, 32'h0000_0000},
    '{1'b1, 32'h8000_0000, 32'h0000_1234, 4'h3, ExternalTgt, 32'h0000_0000},
    '{1'b0, 32'h8000_0000, 32'h0000_0000, 4'hF, ExternalTgt, 32'hDEAD_1234},
    '{1'b1, 32'hFFFF_FFFC, 32'h7654_3210, 4'hF, ExternalTgt, 32'h0000_0000},
    '{1'b0, 32'hFFFF_FFFC, 32'h0000_0000, 4'hF, ExternalTgt, 32'h7654_3210},
    '{1'b0, 32'h0010_0000, 32'h0000_0000, 4'hF, AccelTgt,    32'hA5B5_0000}
  };

  // The fetch path has no decoder, so the window address goes out too
  localparam logic [31:0] Fetches [NumFetches] = '{
    32'h0000_0080, 32'h0000_0084, 32'h0000_0088,
    32'h0000_1000, 32'h0010_0000, 32'hFFFF_FFFC
  };

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  obi_req_t                  core_inst_req;
  obi_rsp_t                  core_inst_rsp;
  obi_req_t                  ext_inst_req;
  obi_rsp_t                  ext_inst_rsp = '0;
  obi_req_t                  core_data_req;
  obi_rsp_t                  core_data_rsp;
  obi_req_t                  ext_data_req;
  obi_rsp_t                  ext_data_rsp = '0;
  periph_req_t               periph_req;
  periph_rsp_t               periph_rsp = '0;
  logic [N_CORES-1:0][1:0]   evt;
  logic [NumIrqs-1:0]        irq;

  logic [31:0] ext_mem [logic [31:0]];
  logic [31:0] gnt_state = Seed;
  obi_req_t    ext_log [$];
  logic [31:0] inst_log [$];
  int          ext_xfers = 0;
  int          periph_xfers = 0;

  always #20 clk_i = ~clk_i;

  core_complex_top #(
    .RegionStart ( RegionStart ),
    .RegionSize  ( RegionSize  ),
    .N_CORES     ( N_CORES     )
  ) core_complex_top_i (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .core_inst_req_i ( core_inst_req ),
    .core_inst_rsp_o ( core_inst_rsp ),
    .ext_inst_req_o  ( ext_inst_req  ),
    .ext_inst_rsp_i  ( ext_inst_rsp  ),
    .core_data_req_i ( core_data_req ),
    .core_data_rsp_o ( core_data_rsp ),
    .ext_data_req_o  ( ext_data_req  ),
    .ext_data_rsp_i  ( ext_data_rsp  ),
    .periph_req_o    ( periph_req    ),
    .periph_rsp_i    ( periph_rsp    ),
    .evt_i           ( evt           ),
    .irq_o           ( irq           )
  );

  bind core_complex_top core_complex_assertions u_bus_checks (
    .clk_i           ( clk_i               ),
    .rst_ni          ( rst_ni              ),
    .core_data_req_i ( core_data_req_i     ),
    .core_data_rsp_i ( core_data_rsp_o     ),
    .ext_data_req_i  ( ext_data_req_o      ),
    .ext_data_rsp_i  ( ext_data_rsp_i      ),
    .periph_req_i    ( periph_req_o        ),
    .ext_sel_req_i   ( data_tgt_req[0].req )
  );

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Unwritten words read back as the inverted address
  function automatic logic [31:0] mem_read(input logic [31:0] waddr);
    if (ext_mem.exists(waddr)) begin
      return ext_mem[waddr];
    end
    return ~waddr;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      report_failure($sformatf("FAILED %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_waited(input string name, input string what, input int waited);
    assert (waited < Timeout) else begin
      report_failure($sformatf("%s: waited %0d cycles for %s and it never came",
                               name, waited, what));
      $fatal(1, "timeout");
    end
  endtask

  task automatic check_idle(input string name);
    check_value({name, " ext_inst req"}, 32'h0, 32'(ext_inst_req.req));
    check_value({name, " ext_data req"}, 32'h0, 32'(ext_data_req.req));
    check_value({name, " periph req"}, 32'h0, 32'(periph_req.req));
  endtask

  task automatic run_access(input int idx);
    access_t  a;
    obi_req_t req;
    obi_req_t seen;
    string    name;
    int       waited;
    a = Accesses[idx];
    name = $sformatf("access %0d %s 0x%08h", idx, a.we ? "write" : "read", a.addr);
    req.req   = 1'b1;
    req.we    = a.we;
    req.be    = a.be;
    req.addr  = a.addr;
    req.wdata = a.wdata;
    @(posedge clk_i);
    core_data_req <= req;
    waited = 0;
    @(negedge clk_i);
    while (!core_data_rsp.gnt) begin
      waited++;
      check_waited(name, "gnt on the core data port", waited);
      @(negedge clk_i);
    end
    // Peripheral requests are visible in the cycle of the core transfer
    if (a.tgt == AccelTgt) begin
      check_value({name, " periph req"}, 32'h1, 32'(periph_req.req));
      check_value({name, " periph wen"}, {31'h0, ~a.we}, 32'(periph_req.wen));
      check_value({name, " periph add"}, a.addr, periph_req.add);
      check_value({name, " periph be"}, 32'(a.be), 32'(periph_req.be));
      check_value({name, " periph id"}, 32'h0, 32'(periph_req.id));
      if (a.we) begin
        check_value({name, " periph data"}, a.wdata, periph_req.data);
      end
    end else begin
      check_value({name, " periph req"}, 32'h0, 32'(periph_req.req));
    end
    @(posedge clk_i);
    core_data_req <= '0;
    waited = 0;
    @(negedge clk_i);
    while (!core_data_rsp.rvalid) begin
      waited++;
      check_waited(name, "rvalid on the core data port", waited);
      @(negedge clk_i);
    end
    if (!a.we) begin
      check_value({name, " rdata"}, a.rdata, core_data_rsp.rdata);
    end
    if (a.tgt == ExternalTgt) begin
      check_value({name, " external transfers queued"}, 32'd1, 32'(ext_log.size()));
      seen = ext_log.pop_front();
      check_value({name, " ext addr"}, a.addr, seen.addr);
      check_value({name, " ext we"}, 32'(a.we), 32'(seen.we));
      check_value({name, " ext be"}, 32'(a.be), 32'(seen.be));
      if (a.we) begin
        check_value({name, " ext wdata"}, a.wdata, seen.wdata);
      end
    end
  endtask

  task automatic run_fetch(input int idx);
    obi_req_t    req;
    logic [31:0] seen_addr;
    string       name;
    int          waited;
    name = $sformatf("fetch %0d 0x%08h", idx, Fetches[idx]);
    req      = '0;
    req.req  = 1'b1;
    req.be   = 4'hF;
    req.addr = Fetches[idx];
    @(posedge clk_i);
    core_inst_req <= req;
    waited = 0;
    @(negedge clk_i);
    while (!core_inst_rsp.gnt) begin
      waited++;
      check_waited(name, "gnt on the core instruction port", waited);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    core_inst_req <= '0;
    waited = 0;
    @(negedge clk_i);
    while (!core_inst_rsp.rvalid) begin
      waited++;
      check_waited(name, "rvalid on the core instruction port", waited);
      @(negedge clk_i);
    end
    check_value({name, " rdata"}, Fetches[idx] ^ InstXor, core_inst_rsp.rdata);
    check_value({name, " fetches queued"}, 32'd1, 32'(inst_log.size()));
    seen_addr = inst_log.pop_front();
    check_value({name, " ext addr"}, Fetches[idx], seen_addr);
  endtask

  // External data memory with random back-pressure
  always @(posedge clk_i) begin
    logic [31:0] waddr;
    logic [31:0] word;
    if (!rst_ni) begin
      ext_data_rsp <= '0;
    end else begin
      gnt_state = next_random(gnt_state);
      ext_data_rsp.gnt    <= (gnt_state[1:0] != 2'b00);
      ext_data_rsp.rvalid <= 1'b0;
      if (ext_data_req.req && ext_data_rsp.gnt) begin
        waddr = {ext_data_req.addr[31:2], 2'b00};
        word  = mem_read(waddr);
        if (ext_data_req.we) begin
          for (int b = 0; b < 4; b++) begin
            if (ext_data_req.be[b]) begin
              word[8*b +: 8] = ext_data_req.wdata[8*b +: 8];
            end
          end
          ext_mem[waddr] = word;
        end
        ext_data_rsp.rvalid <= 1'b1;
        ext_data_rsp.rdata  <= word;
        ext_log.push_back(ext_data_req);
        ext_xfers++;
      end
    end
  end

  // Accelerator configuration port
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      periph_rsp <= '0;
    end else begin
      periph_rsp.gnt     <= 1'b1;
      periph_rsp.r_valid <= 1'b0;
      if (periph_req.req && periph_rsp.gnt) begin
        periph_rsp.r_valid <= 1'b1;
        periph_rsp.r_data  <= periph_req.add ^ PeriphXor;
        periph_xfers++;
      end
    end
  end

  // Instruction memory
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      ext_inst_rsp <= '0;
    end else begin
      ext_inst_rsp.gnt    <= 1'b1;
      ext_inst_rsp.rvalid <= 1'b0;
      if (ext_inst_req.req && ext_inst_rsp.gnt) begin
        ext_inst_rsp.rvalid <= 1'b1;
        ext_inst_rsp.rdata  <= ext_inst_req.addr ^ InstXor;
        inst_log.push_back(ext_inst_req.addr);
      end
    end
  end

  initial begin
    int          ext_expected;
    int          periph_expected;
    logic [31:0] evt_state;
    logic [31:0] pattern;
    logic [31:0] exp_irq;
    ext_expected    = 0;
    periph_expected = 0;
    evt_state       = Seed;
    rst_ni        = 1'b0;
    core_inst_req = '0;
    core_data_req = '0;
    evt           = '0;

    repeat (8) begin
      @(negedge clk_i);
      check_idle("in reset");
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_idle("after reset");

    for (int i = 0; i < NumAccesses; i++) begin
      run_access(i);
      if (Accesses[i].tgt == ExternalTgt) begin
        ext_expected++;
      end else begin
        periph_expected++;
      end
    end
    check_value("external transfer count", 32'(ext_expected), 32'(ext_xfers));
    check_value("peripheral transfer count", 32'(periph_expected), 32'(periph_xfers));
    check_value("leftover external transfers", 32'h0, 32'(ext_log.size()));

    for (int i = 0; i < NumFetches; i++) begin
      run_fetch(i);
    end

    // First pattern is all quiet
    for (int i = 0; i < NumEvtRuns; i++) begin
      evt_state = next_random(evt_state);
      pattern   = (i == 0) ? 32'h0 : evt_state;
      @(posedge clk_i);
      evt <= pattern[2*N_CORES-1:0];
      @(negedge clk_i);
      exp_irq            = '0;
      exp_irq[EvtIrqBit] = |pattern[2*N_CORES-1:0];
      check_value($sformatf("irq for evt 0x%04h", pattern[15:0]), exp_irq, irq);
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== core_complex_assertions.sv ====
/*
  Protocol checks bound into core_complex_top.
  Tracks outstanding core data transfers with a small counter, so it
  assumes fewer than four transfers in flight on the core data port.
*/
`timescale 1ns/1ns
`default_nettype none

module core_complex_assertions
  import cplx_bus_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input obi_req_t    core_data_req_i,
  input obi_rsp_t    core_data_rsp_i,
  input obi_req_t    ext_data_req_i,
  input obi_rsp_t    ext_data_rsp_i,
  input periph_req_t periph_req_i,
  input logic        ext_sel_req_i
);

  logic [1:0] pending_q;
  logic       data_xfer;

  assign data_xfer = core_data_req_i.req & core_data_rsp_i.gnt;

  // Transfers on the core data port still waiting for rvalid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 2'd0;
    end else begin
      pending_q <= pending_q + {1'b0, data_xfer} - {1'b0, core_data_rsp_i.rvalid};
    end
  end

  ext_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ext_data_req_i.req && !ext_data_rsp_i.gnt |=> $stable(ext_data_req_i))
    else $error("external data request changed while waiting for gnt");

  one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(periph_req_i.req && ext_sel_req_i))
    else $error("peripheral and external requests raised together");

  rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_data_rsp_i.rvalid |-> pending_q != 2'd0)
    else $error("rvalid on the core data port with nothing outstanding");

endmodule

`default_nettype wire

// ==== core_complex_top.sv ====
/*
  Bus side of a core plus accelerator complex.
  Data requests inside the accelerator window go to the peripheral port,
  all others through a registered cut to external memory.
  Instruction fetches always pass their own cut. Peripheral id is tied to 0.
*/
`timescale 1ns/1ns
`default_nettype none

module core_complex_top
  import cplx_bus_pkg::*;
  import cplx_map_pkg::*;
#(
  parameter logic [AddrWidth-1:0] RegionStart = DefaultRegionStart,
  parameter logic [AddrWidth-1:0] RegionSize  = DefaultRegionSize,
  parameter int unsigned          N_CORES     = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Instruction side
  input  obi_req_t                 core_inst_req_i,
  output obi_rsp_t                 core_inst_rsp_o,
  output obi_req_t                 ext_inst_req_o,
  input  obi_rsp_t                 ext_inst_rsp_i,
  // Data side
  input  obi_req_t                 core_data_req_i,
  output obi_rsp_t                 core_data_rsp_o,
  output obi_req_t                 ext_data_req_o,
  input  obi_rsp_t                 ext_data_rsp_i,
  // Accelerator configuration
  output periph_req_t              periph_req_o,
  input  periph_rsp_t              periph_rsp_i,
  // Accelerator events and core interrupts
  input  logic [N_CORES-1:0][1:0]  evt_i,
  output logic [NumIrqs-1:0]       irq_o
);

  target_e        data_tgt;
  obi_req_t [1:0] data_tgt_req;
  obi_rsp_t [1:0] data_tgt_rsp;

  obi_spill_cut u_inst_cut (
    .clk_i     ( clk_i           ),
    .rst_ni    ( rst_ni          ),
    .in_req_i  ( core_inst_req_i ),
    .in_rsp_o  ( core_inst_rsp_o ),
    .out_req_o ( ext_inst_req_o  ),
    .out_rsp_i ( ext_inst_rsp_i  )
  );

  region_decoder #(
    .RegionStart ( RegionStart ),
    .RegionSize  ( RegionSize  )
  ) u_decoder (
    .addr_i ( core_data_req_i.addr ),
    .tgt_o  ( data_tgt             )
  );

  obi_target_demux u_demux (
    .clk_i     ( clk_i           ),
    .rst_ni    ( rst_ni          ),
    .tgt_i     ( data_tgt        ),
    .mgr_req_i ( core_data_req_i ),
    .mgr_rsp_o ( core_data_rsp_o ),
    .tgt_req_o ( data_tgt_req    ),
    .tgt_rsp_i ( data_tgt_rsp    )
  );

  obi_spill_cut u_data_cut (
    .clk_i     ( clk_i                     ),
    .rst_ni    ( rst_ni                    ),
    .in_req_i  ( data_tgt_req[ExternalTgt] ),
    .in_rsp_o  ( data_tgt_rsp[ExternalTgt] ),
    .out_req_o ( ext_data_req_o            ),
    .out_rsp_i ( ext_data_rsp_i            )
  );

  // OBI to peripheral protocol, write enable is active low there
  assign periph_req_o.req  = data_tgt_req[AccelTgt].req;
  assign periph_req_o.add  = data_tgt_req[AccelTgt].addr;
  assign periph_req_o.wen  = ~data_tgt_req[AccelTgt].we;
  assign periph_req_o.be   = data_tgt_req[AccelTgt].be;
  assign periph_req_o.data = data_tgt_req[AccelTgt].wdata;
  assign periph_req_o.id   = '0;

  assign data_tgt_rsp[AccelTgt].gnt    = periph_rsp_i.gnt;
  assign data_tgt_rsp[AccelTgt].rvalid = periph_rsp_i.r_valid;
  assign data_tgt_rsp[AccelTgt].rdata  = periph_rsp_i.r_data;

  // All accelerator events share one interrupt line
  always_comb begin
    irq_o            = '0;
    irq_o[EvtIrqBit] = |evt_i;
  end

endmodule

`default_nettype wire

// ==== obi_target_demux.sv ====
/*
  One-to-two OBI demux allowing a single outstanding transaction.
  tgt_i must stay stable with the request until gnt, as the address does.
  After a transfer no new gnt is given until its rvalid has arrived,
  which also blocks gnt in the cycle of that rvalid.
*/
`timescale 1ns/1ns
`default_nettype none

module obi_target_demux
  import cplx_bus_pkg::*;
  import cplx_map_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  target_e        tgt_i,
  input  obi_req_t       mgr_req_i,
  output obi_rsp_t       mgr_rsp_o,
  output obi_req_t [1:0] tgt_req_o,
  input  obi_rsp_t [1:0] tgt_rsp_i
);

  localparam int unsigned NumTgts = 2;

  logic    outstanding_q;
  target_e sel_q;
  logic    xfer;
  logic    rsp_done;

  // Request fans out to all targets, req only to the selected one
  always_comb begin
    for (int unsigned i = 0; i < NumTgts; i++) begin
      tgt_req_o[i]     = mgr_req_i;
      tgt_req_o[i].req = mgr_req_i.req & ~outstanding_q & (tgt_i == target_e'(i));
    end
  end

  assign xfer     = mgr_req_i.req & mgr_rsp_o.gnt;
  assign rsp_done = outstanding_q & tgt_rsp_i[sel_q].rvalid;

  // Track the one transaction in flight and where it went
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
      sel_q         <= ExternalTgt;
    end else begin
      if (xfer) begin
        outstanding_q <= 1'b1;
        sel_q         <= tgt_i;
      end else if (rsp_done) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // gnt from the addressed target, response from the recorded one
  always_comb begin
    mgr_rsp_o.gnt    = tgt_rsp_i[tgt_i].gnt & ~outstanding_q;
    mgr_rsp_o.rvalid = rsp_done;
    mgr_rsp_o.rdata  = tgt_rsp_i[sel_q].rdata;
  end

endmodule

`default_nettype wire

// ==== region_decoder.sv ====
/*
  Combinational address decoder with three rules around one window.
  Addresses that hit no rule fall back to ExternalTgt, which covers the
  top word 0xFFFF_FFFF left out by the exclusive end of the last rule.
  RegionStart + RegionSize must not wrap past the top of the address space.
*/
`timescale 1ns/1ns
`default_nettype none

module region_decoder
  import cplx_bus_pkg::*;
  import cplx_map_pkg::*;
#(
  parameter logic [AddrWidth-1:0] RegionStart = DefaultRegionStart,
  parameter logic [AddrWidth-1:0] RegionSize  = DefaultRegionSize
) (
  input  logic [AddrWidth-1:0] addr_i,
  output target_e              tgt_o
);

  localparam logic [AddrWidth-1:0] RegionEnd = RegionStart + RegionSize;

  // Listed from the highest index down
  localparam addr_rule_t [NumRules-1:0] AddrMap = '{
    // Above the accelerator window
    '{idx: ExternalTgt, start_addr: RegionEnd,   end_addr: '1},
    // Accelerator configuration window
    '{idx: AccelTgt,    start_addr: RegionStart, end_addr: RegionEnd},
    // Below the window
    '{idx: ExternalTgt, start_addr: '0,          end_addr: RegionStart}
  };

  always_comb begin
    tgt_o = ExternalTgt;
    for (int unsigned i = 0; i < NumRules; i++) begin
      if (addr_i >= AddrMap[i].start_addr && addr_i < AddrMap[i].end_addr) begin
        tgt_o = AddrMap[i].idx;
      end
    end
  end

endmodule

`default_nettype wire

// ==== obi_spill_cut.sv ====
/*
  Two-entry registered cut on the OBI request channel.
  Input gnt depends only on the fill level, so no path runs from the
  downstream gnt back to the manager. Responses are not registered.
  Downstream must return rvalid in order, one per granted request.
*/
`timescale 1ns/1ns
`default_nettype none

module obi_spill_cut
  import cplx_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  obi_req_t in_req_i,
  output obi_rsp_t in_rsp_o,
  output obi_req_t out_req_o,
  input  obi_rsp_t out_rsp_i
);

  localparam int unsigned Depth = 2;

  obi_req_t   slot_q [Depth];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;
  logic       full;
  logic       empty;

  assign full  = (count_q == 2'(Depth));
  assign empty = (count_q == 2'd0);

  // Accept while a slot is free
  assign push = in_req_i.req & ~full;
  assign pop  = ~empty & out_rsp_i.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_q[wr_ptr_q] <= in_req_i;
    end
  end

  // Oldest entry drives the downstream port
  always_comb begin
    out_req_o     = slot_q[rd_ptr_q];
    out_req_o.req = ~empty;
  end

  // Grant from fill level, response straight through
  always_comb begin
    in_rsp_o.gnt    = ~full;
    in_rsp_o.rvalid = out_rsp_i.rvalid;
    in_rsp_o.rdata  = out_rsp_i.rdata;
  end

endmodule

`default_nettype wire

// ==== cplx_map_pkg.sv ====
/*
  Address map types for the data side decoder.
  A rule covers start_addr up to end_addr, with end_addr exclusive.
  The region defaults place a 1 KiB accelerator window at 0x0010_0000.
*/
`default_nettype none

package cplx_map_pkg;

  import cplx_bus_pkg::*;

  // Data request targets, also the demux port index
  typedef enum logic [0:0] {
    ExternalTgt = 1'b0,
    AccelTgt    = 1'b1
  } target_e;

  typedef struct packed {
    target_e              idx;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
  } addr_rule_t;

  // Below, inside and above the accelerator window
  parameter int unsigned NumRules = 3;

  parameter logic [AddrWidth-1:0] DefaultRegionStart = 32'h0010_0000;
  parameter logic [AddrWidth-1:0] DefaultRegionSize  = 32'h0000_0400;

endpackage

`default_nettype wire

// ==== cplx_bus_pkg.sv ====
/*
  Bus widths and struct types shared by every port of the core complex.
  OBI carries no id, error or rready signal, so responses return in order.
  The peripheral port uses an active low write enable (wen).
*/
`default_nettype none

package cplx_bus_pkg;

  parameter int unsigned AddrWidth = 32;
  parameter int unsigned DataWidth = 32;
  parameter int unsigned IdWidth   = 8;
  parameter int unsigned BeWidth   = DataWidth / 8;

  // Interrupt vector seen by the core
  parameter int unsigned NumIrqs   = 32;
  parameter int unsigned EvtIrqBit = 3;

  typedef struct packed {
    logic                 req;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic                 gnt;
    logic                 rvalid;
    logic [DataWidth-1:0] rdata;
  } obi_rsp_t;

  // Accelerator configuration port
  typedef struct packed {
    logic                 req;
    logic [AddrWidth-1:0] add;
    logic                 wen;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] data;
    logic [IdWidth-1:0]   id;
  } periph_req_t;

  typedef struct packed {
    logic                 gnt;
    logic [DataWidth-1:0] r_data;
    logic                 r_valid;
  } periph_rsp_t;

endpackage

`default_nettype wire
